//--- rtl/rvdiv_defines.svh
`ifndef RVDIV_DEFINES_SVH
`define RVDIV_DEFINES_SVH

// operand width, one word
`define DIV_XLEN       32

`define DIV_TAG_W      4

// response buffer entries, also the cap on requests in flight
`define DIV_FIFO_DEPTH 4

// wide enough for a full pipe plus a full buffer
`define DIV_CNT_W      ($clog2(`DIV_XLEN + 2 + `DIV_FIFO_DEPTH + 1))

`endif

//--- rtl/rvdiv_pkg.sv
`default_nettype none
`include "rvdiv_defines.svh"

package rvdiv_pkg;

    typedef struct packed {
        logic [`DIV_XLEN-1:0]  dividend;
        logic [`DIV_XLEN-1:0]  divisor;
        logic                  is_signed; // 0 for divu/remu
        logic                  want_rem;  // 0 selects quotient
        logic [`DIV_TAG_W-1:0] tag;
    } div_req_t;

    typedef struct packed {
        logic [`DIV_XLEN-1:0]  result;
        logic [`DIV_TAG_W-1:0] tag;
    } div_rsp_t;

    typedef struct packed {
        logic                  valid;
        logic [`DIV_XLEN-1:0]  rem;      // partial remainder
        logic [`DIV_XLEN-1:0]  quot;
        logic [`DIV_XLEN-1:0]  dvd;      // dividend bits not yet consumed, msb first
        logic [`DIV_XLEN-1:0]  dvs;      // divisor magnitude
        logic                  neg_quot;
        logic                  neg_rem;
        logic                  want_rem;
        logic [`DIV_TAG_W-1:0] tag;
    } div_stage_t;

endpackage

`default_nettype wire

//--- rtl/div_operand_prep.sv
`timescale 1ns/10ps
`default_nettype none
`include "rvdiv_defines.svh"

module div_operand_prep
    import rvdiv_pkg::*;
(
    input  logic       clk,
    input  logic       rstn,
    input  logic       in_valid,
    input  div_req_t   req,
    output div_stage_t stage_out
);

    logic       a_neg;
    logic       b_neg;
    logic       valid_q;
    div_stage_t nxt;
    div_stage_t pay_q;

    assign a_neg = req.is_signed & req.dividend[`DIV_XLEN-1];
    assign b_neg = req.is_signed & req.divisor[`DIV_XLEN-1];

    always_comb begin
        nxt          = '0;
        nxt.valid    = in_valid;
        nxt.dvd      = a_neg ? -req.dividend : req.dividend;
        nxt.dvs      = b_neg ? -req.divisor : req.divisor;
        nxt.neg_quot = (a_neg ^ b_neg) & (|req.divisor); // div by zero keeps all ones
        nxt.neg_rem  = a_neg;
        nxt.want_rem = req.want_rem;
        nxt.tag      = req.tag;
    end

    always_ff @(posedge clk) begin
        pay_q <= nxt;
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= in_valid;
        end
    end

    always_comb begin
        stage_out       = pay_q;
        stage_out.valid = valid_q;
    end

endmodule

`default_nettype wire

//--- rtl/div_cell.sv
`timescale 1ns/10ps
`default_nettype none
`include "rvdiv_defines.svh"

module div_cell
    import rvdiv_pkg::*;
(
    input  logic       clk,
    input  logic       rstn,
    input  div_stage_t stage_in,
    output div_stage_t stage_out
);

    logic [`DIV_XLEN:0] trial;
    logic [`DIV_XLEN:0] diff;
    logic               q_bit;
    logic               valid_q;
    div_stage_t         nxt;
    div_stage_t         pay_q;

    assign trial = {stage_in.rem, stage_in.dvd[`DIV_XLEN-1]}; // bring down next bit
    assign diff  = trial - {1'b0, stage_in.dvs};
    assign q_bit = (trial >= {1'b0, stage_in.dvs});

    always_comb begin
        nxt      = stage_in;
        nxt.rem  = q_bit ? diff[`DIV_XLEN-1:0] : trial[`DIV_XLEN-1:0]; // restore on 0
        nxt.quot = {stage_in.quot[`DIV_XLEN-2:0], q_bit};
        nxt.dvd  = {stage_in.dvd[`DIV_XLEN-2:0], 1'b0};
    end

    always_ff @(posedge clk) begin
        pay_q <= nxt;
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= stage_in.valid;
        end
    end

    always_comb begin
        stage_out       = pay_q;
        stage_out.valid = valid_q;
    end

endmodule

`default_nettype wire

//--- rtl/div_pipe.sv
`timescale 1ns/10ps
`default_nettype none
`include "rvdiv_defines.svh"

module div_pipe
    import rvdiv_pkg::*;
(
    input  logic     clk,
    input  logic     rstn,
    input  logic     in_valid,
    input  div_req_t req,
    output logic     rsp_valid,
    output div_rsp_t rsp
);

    div_stage_t           stage [0:`DIV_XLEN];
    logic [`DIV_XLEN-1:0] q_fix;
    logic [`DIV_XLEN-1:0] r_fix;

    div_operand_prep u_prep (
        .clk       (clk),
        .rstn      (rstn),
        .in_valid  (in_valid),
        .req       (req),
        .stage_out (stage[0])
    );

    // one quotient bit per cell, msb first
    for (genvar i = 0; i < `DIV_XLEN; i++) begin : g_cell
        div_cell u_cell (
            .clk       (clk),
            .rstn      (rstn),
            .stage_in  (stage[i]),
            .stage_out (stage[i+1])
        );
    end

    assign q_fix = stage[`DIV_XLEN].neg_quot ? -stage[`DIV_XLEN].quot : stage[`DIV_XLEN].quot;
    assign r_fix = stage[`DIV_XLEN].neg_rem ? -stage[`DIV_XLEN].rem : stage[`DIV_XLEN].rem;

    always_ff @(posedge clk) begin
        rsp.result <= stage[`DIV_XLEN].want_rem ? r_fix : q_fix;
        rsp.tag    <= stage[`DIV_XLEN].tag;
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= stage[`DIV_XLEN].valid;
        end
    end

endmodule

`default_nettype wire

//--- rtl/div_occupancy_counter.sv
`timescale 1ns/10ps
`default_nettype none
`include "rvdiv_defines.svh"

module div_occupancy_counter (
    input  logic clk,
    input  logic rstn,
    input  logic accept,
    input  logic deliver,
    output logic in_ready
);

    logic [`DIV_CNT_W-1:0] count; // in pipe plus in buffer

    // never more in flight than the buffer can hold
    assign in_ready = (count < `DIV_FIFO_DEPTH);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            count <= '0;
        end else if (accept && !deliver) begin
            count <= count + 1'b1;
        end else if (deliver && !accept) begin
            count <= count - 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- rtl/div_result_fifo.sv
`timescale 1ns/10ps
`default_nettype none
`include "rvdiv_defines.svh"

module div_result_fifo
    import rvdiv_pkg::*;
(
    input  logic     clk,
    input  logic     rstn,
    input  logic     wr_valid,
    input  div_rsp_t wr_data,
    output logic     out_valid,
    input  logic     out_ready,
    output div_rsp_t rsp
);

    localparam int DEPTH = `DIV_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    div_rsp_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             rd_en;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign rd_en     = out_valid & out_ready;
    assign out_valid = (count != '0);
    assign rsp       = mem[rd_ptr]; // head entry

    always_ff @(posedge clk) begin
        if (wr_valid) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_valid) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (rd_en) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            if (wr_valid && !rd_en) begin
                count <= count + 1'b1;
            end else if (rd_en && !wr_valid) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/div_unit.sv
`timescale 1ns/10ps
`default_nettype none

module div_unit
    import rvdiv_pkg::*;
(
    input  logic     clk,
    input  logic     rstn,
    input  logic     in_valid,
    output logic     in_ready,
    input  div_req_t req,
    output logic     out_valid,
    input  logic     out_ready,
    output div_rsp_t rsp
);

    logic     accept;
    logic     deliver;
    logic     pipe_valid;
    div_rsp_t pipe_rsp;

    assign accept  = in_valid & in_ready;
    assign deliver = out_valid & out_ready;

    div_pipe u_pipe (
        .clk       (clk),
        .rstn      (rstn),
        .in_valid  (accept),
        .req       (req),
        .rsp_valid (pipe_valid),
        .rsp       (pipe_rsp)
    );

    div_occupancy_counter u_occ (
        .clk      (clk),
        .rstn     (rstn),
        .accept   (accept),
        .deliver  (deliver),
        .in_ready (in_ready)
    );

    // pipe never stalls, the counter keeps room here
    div_result_fifo u_fifo (
        .clk       (clk),
        .rstn      (rstn),
        .wr_valid  (pipe_valid),
        .wr_data   (pipe_rsp),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .rsp       (rsp)
    );

endmodule

`default_nettype wire

//--- test/div_checker.sv
`timescale 1ns/10ps
`default_nettype none
`include "rvdiv_defines.svh"

module div_checker
    import rvdiv_pkg::*;
(
    input  logic     clk,
    input  logic     rstn,
    input  logic     in_valid,
    input  logic     in_ready,
    input  div_req_t req,
    input  logic     out_valid,
    input  logic     out_ready,
    input  div_rsp_t rsp,
    output int       checks,
    output int       errors,
    output int       pending
);

    localparam logic [`DIV_XLEN-1:0] MIN_VAL = {1'b1, {(`DIV_XLEN-1){1'b0}}};

    div_req_t             pend_q [$]; // accepted but not yet delivered
    div_req_t             sent;
    logic [`DIV_XLEN-1:0] expect_res;
    logic                 armed;

    // RISC-V div/divu/rem/remu
    function automatic logic [`DIV_XLEN-1:0] ref_div(input div_req_t r);
        logic [`DIV_XLEN-1:0] q;
        logic [`DIV_XLEN-1:0] rm;
        if (r.divisor == '0) begin
            q  = '1;
            rm = r.dividend;
        end else if (r.is_signed && r.dividend == MIN_VAL && r.divisor == '1) begin
            q  = MIN_VAL; // overflow case
            rm = '0;
        end else if (r.is_signed) begin
            q  = $signed(r.dividend) / $signed(r.divisor); // truncates toward zero
            rm = $signed(r.dividend) % $signed(r.divisor);
        end else begin
            q  = r.dividend / r.divisor;
            rm = r.dividend % r.divisor;
        end
        return r.want_rem ? rm : q;
    endfunction

    always @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pend_q.delete();
            armed = 1'b1;
        end else begin
            if (armed) begin
                armed = 1'b0;
                checks++;
                if (out_valid || !in_ready) begin
                    errors++;
                    $display("CHECK FAILED at %0t: after reset out_valid=%b in_ready=%b",
                             $time, out_valid, in_ready);
                end
            end
            if (in_ready && pend_q.size() == `DIV_FIFO_DEPTH) begin
                errors++;
                $display("CHECK FAILED at %0t: in_ready high with %0d requests outstanding",
                         $time, pend_q.size());
            end
            if (out_valid && out_ready) begin
                if (pend_q.size() == 0) begin
                    errors++;
                    $display("at %0t a response with tag %0d came out with no request pending",
                             $time, rsp.tag);
                end else begin
                    sent       = pend_q.pop_front(); // oldest first
                    expect_res = ref_div(sent);
                    checks++;
                    if (rsp.result !== expect_res || rsp.tag !== sent.tag) begin
                        errors++;
                        $display("CHECK FAILED at %0t: %h/%h s=%b r=%b got %h t%0d want %h t%0d",
                                 $time, sent.dividend, sent.divisor, sent.is_signed,
                                 sent.want_rem, rsp.result, rsp.tag, expect_res, sent.tag);
                    end
                end
            end
            if (in_valid && in_ready) begin
                pend_q.push_back(req);
            end
        end
        pending = pend_q.size();
    end

endmodule

`default_nettype wire

//--- test/tb_div_unit.sv
`timescale 1ns/10ps
`default_nettype none
`include "rvdiv_defines.svh"

module tb_div_unit
    import rvdiv_pkg::*;
();

    localparam int N_REQ = 332;
    localparam int LIMIT = N_REQ * (`DIV_XLEN + 2 + `DIV_FIFO_DEPTH) + 100;
    localparam logic [31:0] DA [5] = '{32'd7, 32'hffff_fff9, 32'd7, 32'hffff_fff9, 32'd100};
    localparam logic [31:0] DB [5] = '{32'd3, 32'd3, 32'hffff_fffd, 32'hffff_fffd, 32'd9};

    logic        clk;
    logic        rstn;
    logic        in_valid;
    logic        in_ready;
    logic        out_valid;
    logic        out_ready;
    logic        bp; // random out_ready when set
    div_req_t    req;
    div_rsp_t    rsp;
    logic [31:0] lfsr;
    int          tag_cnt;
    int          cycles;
    int          checks;
    int          errors;
    int          pending;
    int          c0;
    int          e0;

    div_unit dut (.*);

    div_checker u_chk (.*);

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > LIMIT) begin
            $display("timeout: responses stopped arriving after %0d cycles", cycles);
            $display("Something failed");
            $finish;
        end
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic step();
        logic [31:0] v;
        @(posedge clk);
        #1;
        take_bits(1, v);
        out_ready = bp ? v[0] : 1'b1;
    endtask

    task automatic issue(input logic [31:0] a, input logic [31:0] b, input logic s,
                         input logic w);
        logic took;
        req.dividend  = a;
        req.divisor   = b;
        req.is_signed = s;
        req.want_rem  = w;
        req.tag       = tag_cnt[`DIV_TAG_W-1:0];
        tag_cnt++;
        in_valid = 1'b1;
        took     = 1'b0;
        while (!took) begin
            took = in_ready; // stable until the next edge
            step();
        end
        in_valid = 1'b0;
    endtask

    task automatic issue_random();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] m;
        take_bits(32, a);
        take_bits(32, b);
        take_bits(3, m);
        if (m[2]) begin
            b = b >> 26; // small divisors with zero now and then
        end
        issue(a, b, m[0], m[1]);
    endtask

    task automatic drain();
        while (pending != 0) begin
            step();
        end
    endtask

    task automatic report(input string name);
        $display("test %-12s %0d checks, %0d errors", name, checks - c0, errors - e0);
        c0 = checks;
        e0 = errors;
    endtask

    initial begin
        clk       = 1'b0;
        rstn      = 1'b0;
        in_valid  = 1'b0;
        out_ready = 1'b1;
        bp        = 1'b0;
        req       = '0;
        lfsr      = 32'he4ad;
        repeat (4) @(posedge clk);
        #1;
        rstn = 1'b1;
        step();
        report("reset");
        for (int i = 0; i < 5; i++) begin
            for (int s = 0; s < 2; s++) begin
                for (int w = 0; w < 2; w++) begin
                    issue(DA[i], DB[i], s[0], w[0]);
                end
            end
        end
        drain();
        report("directed");
        for (int s = 0; s < 2; s++) begin
            for (int w = 0; w < 2; w++) begin
                issue(32'd123, 32'd0, s[0], w[0]);
                issue(32'hffff_fffb, 32'd0, s[0], w[0]);
                issue(32'h8000_0000, 32'hffff_ffff, s[0], w[0]); // overflow when signed
            end
        end
        drain();
        report("corner");
        repeat (200) issue_random();
        drain();
        report("streaming");
        bp = 1'b1;
        repeat (100) issue_random();
        drain();
        report("backpressure");
        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- rvdiv.f
+incdir+rtl
rtl/rvdiv_pkg.sv
rtl/div_operand_prep.sv
rtl/div_cell.sv
rtl/div_pipe.sv
rtl/div_occupancy_counter.sv
rtl/div_result_fifo.sv
rtl/div_unit.sv
test/div_checker.sv
test/tb_div_unit.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module tb_div_unit -f rvdiv.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi
./obj_dir/Vtb_div_unit > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
if grep -q "Something failed" sim.log; then
    exit 1
fi
exit 0
